/* build.f */
source/audio_pkg.sv
source/audio_clk_gen.sv
source/audio_lpf.sv
source/i2s_tx.sv
source/sigma_delta_dac.sv
source/audio_out.sv
sim/audio_out_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module audio_out_tb -Mdir obj_dir -f build.f \
	&& ./obj_dir/Vaudio_out_tb | tee sim.log \
	&& grep -q '^\*\* PASS \*\*$' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/audio_out_tb.sv */
`timescale 1ns/100ps

module audio_out_tb
	import audio_pkg::*;
();

	localparam real CLK_NS = 4.0;
	localparam int RST_CYCLES = 10;
	localparam int FRAME_CLKS = CLK_RATE / AUDIO_RATE;
	localparam int DAC_WINDOW = 65536;

	// whole frames each test needs at 48 kHz
	localparam int RESET_FRAMES = 1;
	localparam int RATE_FRAMES = 10;
	localparam int STEADY_FRAMES = 8;
	localparam int AVERAGE_FRAMES = 8;
	localparam int DAC_FRAMES = 32;
	localparam int TOTAL_FRAMES = RESET_FRAMES + RATE_FRAMES + STEADY_FRAMES + AVERAGE_FRAMES
		+ DAC_FRAMES;
	localparam real WATCHDOG_NS = 1.5 * TOTAL_FRAMES * FRAME_CLKS * CLK_NS;

	logic           clk = 1'b0;
	logic           arst_n;
	logic           sample_rate;
	stereo_sample_t sample_in;
	i2s_bus_t       i2s;
	logic           dac_l;
	logic           dac_r;

	int seed = 26;
	int err_cnt = 0;
	int rst_err_cnt = 0;
	int pass_tests = 0;
	int fail_tests = 0;

	// I2S receiver state
	logic                       bclk_q;
	logic                       lr_q;
	logic [AUDIO_DW-1:0]        sr_l;
	logic [AUDIO_DW-1:0]        sr_r;
	logic signed [AUDIO_DW-1:0] rx_left;
	logic signed [AUDIO_DW-1:0] rx_right;
	int                         frame_cnt;

	audio_out audio_out_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.sample_rate (sample_rate),
		.sample_in   (sample_in),
		.i2s         (i2s),
		.dac_l       (dac_l),
		.dac_r       (dac_r)
	);

	always #(CLK_NS / 2.0) clk = ~clk;

	// a bit belongs to the channel that word select named one bit earlier
	// the right LSB arrives as word select drops, which closes the frame
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bclk_q    <= 1'b0;
			lr_q      <= 1'b0;
			sr_l      <= '0;
			sr_r      <= '0;
			rx_left   <= '0;
			rx_right  <= '0;
			frame_cnt <= 0;
		end else begin
			bclk_q <= i2s.bclk;
			if (i2s.bclk && !bclk_q) begin
				lr_q <= i2s.lrclk;
				if (lr_q) begin
					sr_r <= {sr_r[AUDIO_DW-2:0], i2s.data};
					if (!i2s.lrclk) begin
						rx_left   <= sr_l;
						rx_right  <= {sr_r[AUDIO_DW-2:0], i2s.data};
						frame_cnt <= frame_cnt + 1;
					end
				end else begin
					sr_l <= {sr_l[AUDIO_DW-2:0], i2s.data};
				end
			end
		end
	end

	// outputs stay quiet while reset is held
	reset_quiet: assert property (@(posedge clk) arst_n || (i2s == '0 && !dac_l && !dac_r))
		else begin
			$display("[ERROR] time %0t: reset {i2s, dac_l, dac_r} expected 00000 actual %b%b%b",
				$time, i2s, dac_l, dac_r);
			rst_err_cnt++;
		end

	task automatic check_range(input string name, input int actual, input int lo, input int hi);
		assert (actual >= lo && actual <= hi) else begin
			if (lo == hi) begin
				$display("[ERROR] time %0t: %s expected %0d actual %0d", $time, name, lo, actual);
			end else begin
				$display("[ERROR] time %0t: %s expected %0d to %0d actual %0d",
					$time, name, lo, hi, actual);
			end
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("test %s: passed", name);
			pass_tests++;
		end else begin
			$display("test %s: failed with %0d errors", name, err_cnt - errs_before);
			fail_tests++;
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		while (frame_cnt < target) begin
			@(posedge clk);
		end
	endtask

	task automatic reset_test();
		int errs_before;
		errs_before = err_cnt;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		// the first bit clock edge waits for two master enables, which take about 80 clocks
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			check_range("i2s.bclk", int'(i2s.bclk), 0, 0);
			check_range("i2s.lrclk", int'(i2s.lrclk), 0, 0);
			check_range("i2s.data", int'(i2s.data), 0, 0);
			// a zero level is 0x8000 offset, so each DAC carries first on its third clock
			if (i < 2) begin
				check_range("dac_l", int'(dac_l), 0, 0);
				check_range("dac_r", int'(dac_r), 0, 0);
			end
		end
		err_cnt = err_cnt + rst_err_cnt;
		finish_test("reset state", errs_before);
	endtask

	// counts clocks and bclk rising edges up to the next lrclk falling edge
	task automatic measure_frame(output int len, output int rises);
		logic lr_seen;
		logic bclk_seen;
		logic done;
		len = 0;
		rises = 0;
		done = 1'b0;
		lr_seen = i2s.lrclk;
		bclk_seen = i2s.bclk;
		while (!done) begin
			@(posedge clk);
			len++;
			if (i2s.bclk && !bclk_seen) begin
				rises++;
			end
			if (lr_seen && !i2s.lrclk) begin
				done = 1'b1;
			end
			lr_seen = i2s.lrclk;
			bclk_seen = i2s.bclk;
		end
	endtask

	task automatic check_rate(input logic rate, input int nominal, input string tag);
		int len;
		int rises;
		sample_rate <= rate;
		// the first frame only finds an edge and the second may span the rate change
		measure_frame(len, rises);
		measure_frame(len, rises);
		repeat (3) begin
			measure_frame(len, rises);
			check_range({tag, " i2s.lrclk period"}, len, nominal - 1, nominal + 1);
			check_range({tag, " i2s.bclk rises per frame"}, rises, 32, 32);
		end
	endtask

	task automatic rate_test();
		int errs_before;
		errs_before = err_cnt;
		check_rate(1'b0, FRAME_CLKS, "48 kHz");
		check_rate(1'b1, FRAME_CLKS / 2, "96 kHz");
		sample_rate <= 1'b0;
		wait_frames(1);
		finish_test("frame rate", errs_before);
	endtask

	task automatic steady_test();
		int errs_before;
		logic signed [AUDIO_DW-1:0] l;
		logic signed [AUDIO_DW-1:0] r;
		errs_before = err_cnt;
		repeat (2) begin
			l = AUDIO_DW'($random(seed));
			r = AUDIO_DW'($random(seed));
			wait_frames(1);
			sample_in <= '{left: l, right: r};
			// the frame after the change may latch a half filled history
			wait_frames(3);
			check_range("i2s left word", int'(rx_left), int'(l), int'(l));
			check_range("i2s right word", int'(rx_right), int'(r), int'(r));
		end
		finish_test("steady value through I2S", errs_before);
	endtask

	task automatic average_test();
		int errs_before;
		int target;
		int exp_l;
		int exp_r;
		logic bclk_seen;
		logic use_b;
		logic signed [AUDIO_DW-1:0] la;
		logic signed [AUDIO_DW-1:0] lb;
		logic signed [AUDIO_DW-1:0] ra;
		logic signed [AUDIO_DW-1:0] rb;
		errs_before = err_cnt;
		repeat (2) begin
			la = AUDIO_DW'($random(seed));
			lb = AUDIO_DW'($random(seed));
			ra = AUDIO_DW'($random(seed));
			rb = AUDIO_DW'($random(seed));
			// a window of 32 holds 16 of each value
			exp_l = (16 * int'(la) + 16 * int'(lb)) >>> 5;
			exp_r = (16 * int'(ra) + 16 * int'(rb)) >>> 5;
			wait_frames(1);
			use_b = 1'b0;
			bclk_seen = i2s.bclk;
			sample_in <= '{left: la, right: ra};
			target = frame_cnt + 3;
			while (frame_cnt < target) begin
				@(posedge clk);
				// every bclk edge comes with one filter enable
				if (i2s.bclk != bclk_seen) begin
					bclk_seen = i2s.bclk;
					use_b = !use_b;
					if (use_b) begin
						sample_in <= '{left: lb, right: rb};
					end else begin
						sample_in <= '{left: la, right: ra};
					end
				end
			end
			check_range("i2s left average", int'(rx_left), exp_l, exp_l);
			check_range("i2s right average", int'(rx_right), exp_r, exp_r);
		end
		finish_test("filter averaging", errs_before);
	endtask

	task automatic dac_window(input logic signed [AUDIO_DW-1:0] xl,
		input logic signed [AUDIO_DW-1:0] xr);
		int ones_l;
		int ones_r;
		int exp_l;
		int exp_r;
		ones_l = 0;
		ones_r = 0;
		exp_l = int'(xl) + 32768;
		exp_r = int'(xr) + 32768;
		sample_in <= '{left: xl, right: xr};
		wait_frames(2);
		repeat (DAC_WINDOW) begin
			@(posedge clk);
			if (dac_l) begin
				ones_l++;
			end
			if (dac_r) begin
				ones_r++;
			end
		end
		check_range("dac_l ones", ones_l, exp_l - 1, exp_l + 1);
		check_range("dac_r ones", ones_r, exp_r - 1, exp_r + 1);
	endtask

	task automatic dac_test();
		int errs_before;
		errs_before = err_cnt;
		dac_window(AUDIO_DW'($random(seed)), AUDIO_DW'($random(seed)));
		dac_window(AUDIO_DW'(-32768), AUDIO_DW'($random(seed)));
		finish_test("DAC density", errs_before);
	endtask

	initial begin
		arst_n = 1'b0;
		sample_rate = 1'b0;
		sample_in = '0;
		reset_test();
		rate_test();
		steady_test();
		average_test();
		dac_test();
		$display("tests passed %0d, tests failed %0d, errors %0d",
			pass_tests, fail_tests, err_cnt);
		if (fail_tests == 0 && err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0.0f ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* source/audio_clk_gen.sv */
`timescale 1ns/100ps

module audio_clk_gen
	import audio_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	// 0 selects 48 kHz, 1 selects 96 kHz
	input  logic sample_rate,
	output logic mclk_ce,
	output logic i2s_ce,
	output logic lpf_ce
);

	logic [31:0] step;
	logic [31:0] phase;
	logic [31:0] phase_sum;
	logic        i2s_div;
	logic [7:0]  lpf_cnt;

	// doubling the step doubles every rate derived from it
	assign step = sample_rate ? 32'(CE_RATE * 2) : 32'(CE_RATE);
	assign phase_sum = phase + step;

	// fractional divide, the phase never gets near 2**32 since it stays below CLK_RATE
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase   <= '0;
			mclk_ce <= 1'b0;
		end else begin
			mclk_ce <= 1'b0;
			if (phase_sum >= CLK_RATE) begin
				phase   <= phase_sum - CLK_RATE;
				mclk_ce <= 1'b1;
			end else begin
				phase <= phase_sum;
			end
		end
	end

	// every second master enable becomes a bit clock half period
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			i2s_div <= 1'b0;
			i2s_ce  <= 1'b0;
		end else begin
			i2s_ce <= 1'b0;
			if (mclk_ce) begin
				i2s_div <= ~i2s_div;
				i2s_ce  <= i2s_div;
			end
		end
	end

	// filter enable every LPF_DIV+1 master enables, 64 per sample period
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lpf_cnt <= '0;
			lpf_ce  <= 1'b0;
		end else begin
			lpf_ce <= 1'b0;
			if (mclk_ce) begin
				if (lpf_cnt == LPF_DIV[7:0]) begin
					lpf_cnt <= '0;
					lpf_ce  <= 1'b1;
				end else begin
					lpf_cnt <= lpf_cnt + 8'd1;
				end
			end
		end
	end

endmodule

/* source/audio_lpf.sv */
`timescale 1ns/100ps

module audio_lpf
	import audio_pkg::*;
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       ce,
	input  logic signed [AUDIO_DW-1:0] sample_in,
	output logic signed [AUDIO_DW-1:0] sample_out
);

	logic signed [AUDIO_DW-1:0]           hist [LPF_TAPS];
	logic signed [AUDIO_DW+LPF_SHIFT-1:0] sum;
	logic signed [AUDIO_DW+LPF_SHIFT-1:0] sum_in;
	logic signed [AUDIO_DW+LPF_SHIFT-1:0] sum_out;

	// sign extend the sample entering and the one leaving the window
	assign sum_in = (AUDIO_DW + LPF_SHIFT)'(sample_in);
	assign sum_out = (AUDIO_DW + LPF_SHIFT)'(hist[LPF_TAPS-1]);

	// the history is shifted one place per enable, oldest at the top
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < LPF_TAPS; i++) begin
				hist[i] <= '0;
			end
		end else if (ce) begin
			for (int i = LPF_TAPS - 1; i > 0; i--) begin
				hist[i] <= hist[i-1];
			end
			hist[0] <= sample_in;
		end
	end

	// sum always equals the total of the history as it stands now
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum <= '0;
		end else if (ce) begin
			sum <= sum + sum_in - sum_out;
		end
	end

	// the output takes the average of the history before this enable's shift
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sample_out <= '0;
		end else if (ce) begin
			sample_out <= sum[AUDIO_DW+LPF_SHIFT-1:LPF_SHIFT];
		end
	end

endmodule

/* source/audio_out.sv */
`timescale 1ns/100ps

module audio_out
	import audio_pkg::*;
(
	input  logic           clk,
	input  logic           arst_n,
	// 0 selects 48 kHz, 1 selects 96 kHz
	input  logic           sample_rate,
	input  stereo_sample_t sample_in,
	output i2s_bus_t       i2s,
	output logic           dac_l,
	output logic           dac_r
);

	logic                       i2s_ce;
	logic                       lpf_ce;
	logic signed [AUDIO_DW-1:0] filt_l;
	logic signed [AUDIO_DW-1:0] filt_r;
	stereo_sample_t             filt;
	logic [AUDIO_DW-1:0]        level_l;
	logic [AUDIO_DW-1:0]        level_r;

	// the master enable only paces the two dividers inside the generator
	audio_clk_gen audio_clk_gen_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.sample_rate (sample_rate),
		.mclk_ce     (),
		.i2s_ce      (i2s_ce),
		.lpf_ce      (lpf_ce)
	);

	audio_lpf audio_lpf_l (
		.clk        (clk),
		.arst_n     (arst_n),
		.ce         (lpf_ce),
		.sample_in  (sample_in.left),
		.sample_out (filt_l)
	);

	audio_lpf audio_lpf_r (
		.clk        (clk),
		.arst_n     (arst_n),
		.ce         (lpf_ce),
		.sample_in  (sample_in.right),
		.sample_out (filt_r)
	);

	assign filt = '{left: filt_l, right: filt_r};

	i2s_tx i2s_tx_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (i2s_ce),
		.sample (filt),
		.i2s    (i2s)
	);

	// flipping the sign bit turns two's complement into offset binary
	assign level_l = {~filt.left[AUDIO_DW-1], filt.left[AUDIO_DW-2:0]};
	assign level_r = {~filt.right[AUDIO_DW-1], filt.right[AUDIO_DW-2:0]};

	sigma_delta_dac sigma_delta_dac_l (
		.clk    (clk),
		.arst_n (arst_n),
		.level  (level_l),
		.dout   (dac_l)
	);

	sigma_delta_dac sigma_delta_dac_r (
		.clk    (clk),
		.arst_n (arst_n),
		.level  (level_r),
		.dout   (dac_r)
	);

endmodule

/* source/audio_pkg.sv */
package audio_pkg;

	// system clock, matching the 4 ns simulation clock
	localparam int unsigned CLK_RATE = 250_000_000;

	// base sample rate and sample width
	localparam int unsigned AUDIO_RATE = 48_000;
	localparam int unsigned AUDIO_DW = 16;

	// master enable rate, 6.144 MHz at the base rate
	localparam int unsigned CE_RATE = AUDIO_RATE * AUDIO_DW * 8;

	// moving-average depth and the matching divide shift
	localparam int unsigned LPF_TAPS = 32;
	localparam int unsigned LPF_SHIFT = 5;

	// master enables per filter enable, minus one
	localparam int unsigned LPF_DIV = 1;

	typedef struct packed {
		logic signed [AUDIO_DW-1:0] left;
		logic signed [AUDIO_DW-1:0] right;
	} stereo_sample_t;

	typedef struct packed {
		logic bclk;
		logic lrclk;
		logic data;
	} i2s_bus_t;

endpackage

/* source/i2s_tx.sv */
`timescale 1ns/100ps

module i2s_tx
	import audio_pkg::*;
(
	input  logic           clk,
	input  logic           arst_n,
	input  logic           ce,
	input  stereo_sample_t sample,
	output i2s_bus_t       i2s
);

	logic                  bclk;
	logic                  lrclk;
	logic [4:0]            bit_cnt;
	logic [4:0]            bit_next;
	logic                  lr_next;
	logic [2*AUDIO_DW-1:0] shift;

	assign bit_next = bit_cnt + 5'd1;

	// left bits go out on counts 0 to 15 and right bits on 16 to 31
	// word select leads each word by one bit, so it is high for 15 to 30
	assign lr_next = (bit_next >= 5'(AUDIO_DW - 1)) && (bit_next != 5'(2 * AUDIO_DW - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bclk <= 1'b0;
		end else if (ce) begin
			bclk <= ~bclk;
		end
	end

	// count 31 after reset so the first falling edge starts a frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= 5'd31;
			lrclk   <= 1'b0;
		end else if (ce && bclk) begin
			bit_cnt <= bit_next;
			lrclk   <= lr_next;
		end
	end

	// both channels are latched together at the start of the frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shift <= '0;
		end else if (ce && bclk) begin
			if (bit_next == 5'd0) begin
				shift <= sample;
			end else begin
				shift <= {shift[2*AUDIO_DW-2:0], 1'b0};
			end
		end
	end

	// data and word select only move on bclk falling, the receiver samples on rising
	assign i2s = '{bclk: bclk, lrclk: lrclk, data: shift[2*AUDIO_DW-1]};

endmodule

/* source/sigma_delta_dac.sv */
`timescale 1ns/100ps

module sigma_delta_dac
	import audio_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	// offset binary, 0 is full negative scale
	input  logic [AUDIO_DW-1:0] level,
	output logic                dout
);

	logic [AUDIO_DW:0] acc;

	// first order modulator, the carry out of the error sum is the output bit
	// over 2**16 clocks the number of carries equals level to within one
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[AUDIO_DW-1:0]} + {1'b0, level};
		end
	end

	assign dout = acc[AUDIO_DW];

endmodule
